// File: Bender.yml
package:
  name: risk_gate

sources:
  # packages first, then the module tree bottom up
  - source/limit_table_pkg.sv
  - source/risk_cmd_pkg.sv
  - source/client_limit_ram.sv
  - source/risk_checker.sv
  - source/risk_gate_top.sv

  - target: simulation
    files:
      - sim/risk_gate_assertions.sv
      - sim/risk_gate_tb.sv

// File: sim/risk_gate_assertions.sv
/*
 * Timing and update checks on the risk checker pipeline.
 * Bound into every risk_checker instance.
 */
module risk_gate_assertions (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       cmd_valid,
  input limit_table_pkg::table_op_t upd_op,
  input logic                       verdict_valid
);

  import limit_table_pkg::*;

  // fixed two cycle latency in both directions
  latency_two: assert property (@(posedge clk) disable iff (!arst_n)
    verdict_valid == $past(cmd_valid, 2))
    else $error("verdict_valid does not follow cmd_valid by two cycles");

  // no strobe in the previous cycle leaves stage 1 empty
  // and an empty stage 1 never writes the table
  no_write_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !$past(cmd_valid) |-> upd_op == op_none)
    else $error("table update issued with stage 1 empty");

  quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !verdict_valid)
    else $error("verdict_valid high during reset");

endmodule

bind risk_checker risk_gate_assertions assertions_i (
  .clk           (clk),
  .arst_n        (arst_n),
  .cmd_valid     (cmd_valid),
  .upd_op        (upd_op),
  .verdict_valid (verdict_valid)
);

// File: sim/risk_gate_tb.sv
/*
 * Testbench for the pre-trade risk gate.
 * Directed tests drive commands on the falling edge and compare each
 * verdict against a reference model of the limit table two cycles later.
 */
module risk_gate_tb;

  import limit_table_pkg::*;
  import risk_cmd_pkg::*;

  localparam int clk_period = 100;
  // commands issued over all tests
  localparam int total_cmds = 225;
  // slack for idles and drains
  localparam int margin     = 300;

  logic          clk;
  logic          arst_n;
  logic          cmd_valid;
  risk_cmd_t     cmd;
  logic          verdict_valid;
  risk_verdict_t verdict;

  // reference copy of the table
  limit_entry_t  model [num_clients];
  // expected verdicts and the cycle each is due in
  risk_verdict_t exp_q [$];
  int unsigned   due_q [$];
  int unsigned   cycle;

  risk_gate_top dut_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .verdict_valid (verdict_valid),
    .verdict       (verdict)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t: verdict_valid expected %b got %b",
                               $time, exp, got));
    end
  endtask

  task automatic check_verdict(input risk_verdict_t got, input risk_verdict_t exp);
    if (got.client !== exp.client) begin
      report_failure($sformatf("Mismatch at %0t: verdict.client expected %0d got %0d",
                               $time, exp.client, got.client));
    end
    if (got.kind !== exp.kind) begin
      report_failure($sformatf("Mismatch at %0t: verdict.kind expected %0d got %0d",
                               $time, exp.kind, got.kind));
    end
    if (got.accepted !== exp.accepted) begin
      report_failure($sformatf("Mismatch at %0t: verdict.accepted expected %b got %b",
                               $time, exp.accepted, got.accepted));
    end
    if (got.accumulated !== exp.accumulated) begin
      report_failure($sformatf("Mismatch at %0t: verdict.accumulated expected %0d got %0d",
                               $time, exp.accumulated, got.accumulated));
    end
    if (got.max_to_trade !== exp.max_to_trade) begin
      report_failure($sformatf("Mismatch at %0t: verdict.max_to_trade expected %0d got %0d",
                               $time, exp.max_to_trade, got.max_to_trade));
    end
  endtask

  // apply the command rules to the model and form the verdict
  task automatic predict(input risk_cmd_t c, output risk_verdict_t v);
    limit_entry_t e;
    int unsigned  sum;
    e          = model[c.client];
    v.client   = c.client;
    v.kind     = c.kind;
    v.accepted = 1'b0;
    case (c.kind)
      cmd_order: begin
        // full-width sum so a 16 bit wrap can never pass
        sum = int'(e.accumulated) + int'(c.payload.order_qty);
        if (sum <= int'(e.max_to_trade)) begin
          v.accepted    = 1'b1;
          e.accumulated = amount_t'(sum);
        end
      end
      cmd_set_limit: begin
        v.accepted     = 1'b1;
        e.max_to_trade = c.payload.new_limit;
      end
      cmd_clear: begin
        v.accepted    = 1'b1;
        e.accumulated = '0;
      end
      default: begin
      end
    endcase
    model[c.client] = e;
    v.accumulated   = e.accumulated;
    v.max_to_trade  = e.max_to_trade;
  endtask

  // outputs are stable at the falling edge
  task automatic check_outputs();
    logic exp_valid;
    exp_valid = (due_q.size() > 0) && (due_q[0] == cycle);
    check_valid(verdict_valid, exp_valid);
    if (exp_valid) begin
      check_verdict(verdict, exp_q.pop_front());
      void'(due_q.pop_front());
    end
  endtask

  task automatic issue_cmd(input cmd_kind_t kind, input client_id_t client,
                           input amount_t value);
    risk_cmd_t     c;
    risk_verdict_t v;
    c.kind   = kind;
    c.client = client;
    if (kind == cmd_set_limit) begin
      c.payload.new_limit = value;
    end else begin
      c.payload.order_qty = value;
    end
    @(negedge clk);
    check_outputs();
    cmd_valid = 1'b1;
    cmd       = c;
    predict(c, v);
    exp_q.push_back(v);
    due_q.push_back(cycle + 2);
    cycle++;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    check_outputs();
    cmd_valid = 1'b0;
    cmd       = '0;
    cycle++;
  endtask

  // let every queued verdict come out
  task automatic drain();
    idle_cycle();
    while (due_q.size() > 0) begin
      idle_cycle();
    end
  endtask

  // table is all zeros so nonzero orders fail
  task automatic no_limit_rejects();
    issue_cmd(cmd_order, 10'd0, 16'd1);
    issue_cmd(cmd_order, 10'd5, 16'd100);
    issue_cmd(cmd_order, 10'd1023, 16'hffff);
    drain();
  endtask

  task automatic orders_within_limit();
    issue_cmd(cmd_set_limit, 10'd3, 16'd1000);
    issue_cmd(cmd_order, 10'd3, 16'd100);
    issue_cmd(cmd_order, 10'd3, 16'd250);
    // lands exactly on the limit
    issue_cmd(cmd_order, 10'd3, 16'd650);
    drain();
  endtask

  task automatic orders_past_limit();
    issue_cmd(cmd_order, 10'd3, 16'd1);
    issue_cmd(cmd_set_limit, 10'd7, 16'hffff);
    issue_cmd(cmd_order, 10'd7, 16'hff00);
    // sum wraps 16 bits
    issue_cmd(cmd_order, 10'd7, 16'h0200);
    issue_cmd(cmd_order, 10'd7, 16'h00ff);
    drain();
  endtask

  // no gaps between commands
  // same client and mixed clients
  task automatic back_to_back_cmds();
    issue_cmd(cmd_set_limit, 10'd10, 16'd500);
    issue_cmd(cmd_order, 10'd10, 16'd300);
    issue_cmd(cmd_order, 10'd10, 16'd300);
    issue_cmd(cmd_set_limit, 10'd11, 16'd50);
    issue_cmd(cmd_order, 10'd10, 16'd200);
    issue_cmd(cmd_order, 10'd11, 16'd40);
    issue_cmd(cmd_order, 10'd11, 16'd20);
    issue_cmd(cmd_clear, 10'd10, 16'd0);
    issue_cmd(cmd_order, 10'd10, 16'd300);
    issue_cmd(cmd_order, 10'd11, 16'd10);
    drain();
  endtask

  task automatic clear_restores_room();
    issue_cmd(cmd_order, 10'd3, 16'd500);
    issue_cmd(cmd_clear, 10'd3, 16'd0);
    issue_cmd(cmd_order, 10'd3, 16'd500);
    drain();
  endtask

  task automatic random_burst();
    cmd_kind_t  kind;
    client_id_t client;
    amount_t    value;
    for (int i = 0; i < 200; i++) begin
      kind   = cmd_kind_t'($urandom_range(2, 0));
      client = client_id_t'($urandom_range(3, 0));
      // small orders against wide limits so both verdicts show up
      if (kind == cmd_set_limit) begin
        value = amount_t'($urandom_range(16'hffff, 0));
      end else begin
        value = amount_t'($urandom_range(3000, 0));
      end
      issue_cmd(kind, client, value);
      if ($urandom_range(3, 0) == 0) begin
        idle_cycle();
      end
    end
    drain();
  endtask

  // run limit from the test length
  initial begin
    #((total_cmds + margin) * clk_period);
    report_failure("Timeout: the tests did not complete in time");
  end

  initial begin
    void'($urandom(32'h7725d533));
    clk       = 1'b0;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    cycle     = 0;
    for (int i = 0; i < num_clients; i++) begin
      model[i] = '0;
    end
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    no_limit_rejects();
    orders_within_limit();
    orders_past_limit();
    back_to_back_cmds();
    clear_restores_room();
    random_burst();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: source/client_limit_ram.sv
/*
 * Per-client limit memory.
 * Asynchronous read port for the checker and one update port
 * doing read-modify-write of the addressed entry on the clock edge.
 */
module client_limit_ram (
  input  logic                          clk,
  // read port
  input  limit_table_pkg::client_id_t   rd_client,
  output limit_table_pkg::limit_entry_t rd_entry,
  // update port
  input  limit_table_pkg::table_op_t    upd_op,
  input  limit_table_pkg::client_id_t   upd_client,
  input  limit_table_pkg::amount_t      upd_value
);

  import limit_table_pkg::*;

  // table storage
  limit_entry_t mem [num_clients];

  // entry as it will be after the update
  limit_entry_t upd_entry;
  logic         upd_we;

  // all clients start with zero limit and zero traded total
  // so every order is rejected until a limit is set
  initial begin
    for (int i = 0; i < num_clients; i++) begin
      mem[i] = '0;
    end
  end

  // zero latency read
  assign rd_entry = mem[rd_client];

  // modify step of the update
  // fields not touched by the op keep their stored value
  always_comb begin
    upd_entry = mem[upd_client];
    upd_we    = 1'b1;
    case (upd_op)
      op_set_max: begin
        // traded total is kept
        upd_entry.max_to_trade = upd_value;
      end
      op_add_acc: begin
        // checker already made sure this cannot wrap
        upd_entry.accumulated = upd_entry.accumulated + upd_value;
      end
      op_clear_acc: begin
        // limit is kept
        upd_entry.accumulated = '0;
      end
      default: begin
        // op_none
        upd_we = 1'b0;
      end
    endcase
  end

  // write step
  // lands at the edge so a read in the next cycle sees it
  always @(posedge clk) begin
    if (upd_we) begin
      mem[upd_client] <= upd_entry;
    end
  end

endmodule

// File: source/limit_table_pkg.sv
/*
 * Limit table definitions for the pre-trade risk gate.
 * Fixes the table geometry and the per-client entry word
 * together with the update operations the table applies.
 */
package limit_table_pkg;

  // one entry per client
  localparam int num_clients = 1024;
  localparam int client_w    = 10;

  // quantities and limits share one width
  localparam int amount_w    = 16;

  // client index into the table
  typedef logic [client_w-1:0] client_id_t;

  // traded quantity or trading limit
  typedef logic [amount_w-1:0] amount_t;

  // table word
  // upper half is the limit, lower half the running traded total
  typedef struct packed {
    amount_t max_to_trade;
    amount_t accumulated;
  } limit_entry_t;

  // update applied by the table at the next clock edge
  typedef enum logic [1:0] {
    // leave the entry untouched
    op_none      = 2'd0,
    // replace the limit field
    op_set_max   = 2'd1,
    // add upd_value to the traded total
    op_add_acc   = 2'd2,
    // start a new trading day
    op_clear_acc = 2'd3
  } table_op_t;

endpackage

// File: source/risk_checker.sv
/*
 * Two-stage risk check pipeline.
 * Stage 1 registers the command. Stage 2 reads the client entry,
 * decides on the command, drives the table update and registers
 * the verdict with the post-command entry values.
 */
module risk_checker (
  input  logic                          clk,
  input  logic                          arst_n,
  // command input without back-pressure
  input  logic                          cmd_valid,
  input  risk_cmd_pkg::risk_cmd_t       cmd,
  // table read
  output limit_table_pkg::client_id_t   rd_client,
  input  limit_table_pkg::limit_entry_t rd_entry,
  // table update
  output limit_table_pkg::table_op_t    upd_op,
  output limit_table_pkg::client_id_t   upd_client,
  output limit_table_pkg::amount_t      upd_value,
  // verdict output
  output logic                          verdict_valid,
  output risk_cmd_pkg::risk_verdict_t   verdict
);

  import limit_table_pkg::*;
  import risk_cmd_pkg::*;

  // stage 1
  logic         s1_valid;
  risk_cmd_t    s1_cmd;

  // stage 2 decision
  // one extra bit so an overflowing sum is never accepted
  logic [amount_w:0] order_sum;
  logic              order_fits;
  table_op_t         next_op;
  logic              next_accepted;
  limit_entry_t      next_entry;

  // stage 1 valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cmd_valid;
    end
  end

  // stage 1 command
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      s1_cmd <= cmd;
    end
  end

  // entry lookup straight from stage 1
  // previous command's write has landed by now so no forwarding
  assign rd_client = s1_cmd.client;

  // limit check for orders
  assign order_sum  = {1'b0, rd_entry.accumulated} + {1'b0, s1_cmd.payload.order_qty};
  assign order_fits = (order_sum <= {1'b0, rd_entry.max_to_trade});

  // pick the table op and the resulting entry
  always_comb begin
    next_op       = op_none;
    next_accepted = 1'b0;
    next_entry    = rd_entry;
    // same payload bits carry the order quantity or the new limit
    upd_value     = s1_cmd.payload.order_qty;
    case (s1_cmd.kind)
      cmd_order: begin
        // rejected order leaves the entry alone
        if (order_fits) begin
          next_op                = op_add_acc;
          next_accepted          = 1'b1;
          next_entry.accumulated = order_sum[amount_w-1:0];
        end
      end
      cmd_set_limit: begin
        next_op                 = op_set_max;
        next_accepted           = 1'b1;
        next_entry.max_to_trade = s1_cmd.payload.new_limit;
      end
      cmd_clear: begin
        next_op                = op_clear_acc;
        next_accepted          = 1'b1;
        next_entry.accumulated = '0;
      end
      default: begin
        // unused opcode is rejected
        next_op = op_none;
      end
    endcase
    // nothing in stage 1 means no write
    if (!s1_valid) begin
      next_op = op_none;
    end
  end

  // table update lands at the edge ending this cycle
  assign upd_op     = next_op;
  assign upd_client = s1_cmd.client;

  // verdict strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      verdict_valid <= 1'b0;
    end else begin
      verdict_valid <= s1_valid;
    end
  end

  // verdict payload
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      verdict.client       <= s1_cmd.client;
      verdict.kind         <= s1_cmd.kind;
      verdict.accepted     <= next_accepted;
      verdict.accumulated  <= next_entry.accumulated;
      verdict.max_to_trade <= next_entry.max_to_trade;
    end
  end

endmodule

// File: source/risk_cmd_pkg.sv
/*
 * Command and verdict formats of the pre-trade risk gate.
 * A command carries one payload word whose meaning depends
 * on the opcode. Every command returns one verdict.
 */
package risk_cmd_pkg;

  import limit_table_pkg::*;

  // command opcode
  // value 3 is unused and gets a rejected verdict
  typedef enum logic [1:0] {
    // trade request against the client's limit
    cmd_order     = 2'd0,
    // replace the client's limit
    cmd_set_limit = 2'd1,
    // reset the client's traded total
    cmd_clear     = 2'd2
  } cmd_kind_t;

  // payload word
  // order quantity for cmd_order, new limit for cmd_set_limit
  // ignored by cmd_clear
  typedef union packed {
    amount_t order_qty;
    amount_t new_limit;
  } cmd_payload_u;

  // incoming command
  typedef struct packed {
    cmd_kind_t    kind;
    client_id_t   client;
    cmd_payload_u payload;
  } risk_cmd_t;

  // verdict returned two cycles after the command
  // entry fields hold the values after the command took effect
  typedef struct packed {
    client_id_t client;
    cmd_kind_t  kind;
    // always set for limit updates and clears
    logic       accepted;
    amount_t    accumulated;
    amount_t    max_to_trade;
  } risk_verdict_t;

endpackage

// File: source/risk_gate_top.sv
/*
 * Pre-trade risk gate top level.
 * Connects the risk checker to the per-client limit table.
 * Verdicts come out two cycles after each command.
 */
module risk_gate_top (
  input  logic                        clk,
  input  logic                        arst_n,
  // command strobe and payload
  input  logic                        cmd_valid,
  input  risk_cmd_pkg::risk_cmd_t     cmd,
  // verdict strobe and payload
  output logic                        verdict_valid,
  output risk_cmd_pkg::risk_verdict_t verdict
);

  import limit_table_pkg::*;

  // table read path
  client_id_t   rd_client;
  limit_entry_t rd_entry;

  // table update path
  table_op_t    upd_op;
  client_id_t   upd_client;
  amount_t      upd_value;

  // decision pipeline
  risk_checker checker_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .rd_client     (rd_client),
    .rd_entry      (rd_entry),
    .upd_op        (upd_op),
    .upd_client    (upd_client),
    .upd_value     (upd_value),
    .verdict_valid (verdict_valid),
    .verdict       (verdict)
  );

  // limit storage
  client_limit_ram table_i (
    .clk        (clk),
    .rd_client  (rd_client),
    .rd_entry   (rd_entry),
    .upd_op     (upd_op),
    .upd_client (upd_client),
    .upd_value  (upd_value)
  );

endmodule

// File: tb.f
source/limit_table_pkg.sv
source/risk_cmd_pkg.sv
source/client_limit_ram.sv
source/risk_checker.sv
source/risk_gate_top.sv
sim/risk_gate_assertions.sv
sim/risk_gate_tb.sv
